// ==== rtl/bpuPkg.sv ====
// shared sizes and encodings for the branch prediction unit
// PCs are byte addresses and always word aligned, so bits 1:0 are ignored
package bpuPkg;

    // address width of fetch and execute PCs
    localparam int pcWidth = 32;

    // direction table indexed by pc[9:2]
    localparam int bhtIndexWidth = 8;
    localparam int bhtDepth = 1 << bhtIndexWidth;

    // target buffer indexed by pc[6:2], tagged with pc[31:7]
    localparam int btbIndexWidth = 5;
    localparam int btbTagWidth = pcWidth - btbIndexWidth - 2;
    localparam int btbDepth = 1 << btbIndexWidth;

    // return stack, pointer wraps on overflow and underflow
    localparam int rasPtrWidth = 4;
    localparam int rasDepth = 1 << rasPtrWidth;

    // two-bit saturating counter states
    localparam logic [1:0] ctrStrongNotTaken = 2'd0;
    localparam logic [1:0] ctrWeakNotTaken = 2'd1;
    localparam logic [1:0] ctrWeakTaken = 2'd2;
    localparam logic [1:0] ctrStrongTaken = 2'd3;

    // branch kinds reported by execute
    // not a control-flow instruction
    localparam logic [1:0] kindNone = 2'd0;
    // jr through r31
    localparam logic [1:0] kindReturn = 2'd1;
    // conditional branch, or other direct / indirect jump
    localparam logic [1:0] kindJump = 2'd2;
    // jump-and-link
    localparam logic [1:0] kindCall = 2'd3;

    // return address sits past the delay slot
    localparam logic [pcWidth-1:0] returnOffset = 8;

    // sequential fetch step
    localparam logic [pcWidth-1:0] fetchStride = 4;

endpackage

// ==== rtl/branchHistoryTable.sv ====
// 256 two-bit counters, no tags, so aliasing branches share a counter
// read is combinational on pc; an update lands at the end of its cycle
`timescale 1ns/100ps

module branchHistoryTable (
    input  logic                       clk,
    input  logic                       resetn,
    // fetch lookup
    input  logic [bpuPkg::pcWidth-1:0] pc,
    // execute report
    input  logic                       exValid,
    input  logic [bpuPkg::pcWidth-1:0] exPc,
    input  logic                       exTaken,
    input  logic                       exUncond,
    // direction for the fetch PC
    output logic                       taken
);

    // counter storage
    logic [1:0] ctrArr [bpuPkg::bhtDepth];

    // word index, pc[9:2]
    logic [bpuPkg::bhtIndexWidth-1:0] rdIndex;
    logic [bpuPkg::bhtIndexWidth-1:0] wrIndex;

    // counter being trained and its next value
    logic [1:0] ctrCur;
    logic [1:0] ctrNext;

    assign rdIndex = pc[bpuPkg::bhtIndexWidth+1:2];
    assign wrIndex = exPc[bpuPkg::bhtIndexWidth+1:2];
    assign ctrCur = ctrArr[wrIndex];

    // saturating step toward the resolved direction
    always_comb begin
        if (exUncond) begin
            // always-taken jumps go straight to strong taken
            ctrNext = bpuPkg::ctrStrongTaken;
        end else begin
            case (ctrCur)
                bpuPkg::ctrStrongNotTaken: begin
                    ctrNext = exTaken ? bpuPkg::ctrWeakNotTaken
                                      : bpuPkg::ctrStrongNotTaken;
                end
                bpuPkg::ctrWeakNotTaken: begin
                    ctrNext = exTaken ? bpuPkg::ctrWeakTaken
                                      : bpuPkg::ctrStrongNotTaken;
                end
                bpuPkg::ctrWeakTaken: begin
                    ctrNext = exTaken ? bpuPkg::ctrStrongTaken
                                      : bpuPkg::ctrWeakNotTaken;
                end
                default: begin
                    // strong taken only falls back one step
                    ctrNext = exTaken ? bpuPkg::ctrStrongTaken
                                      : bpuPkg::ctrWeakTaken;
                end
            endcase
        end
    end

    // whole table back to strong not taken on reset
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < bpuPkg::bhtDepth; i++) begin
                ctrArr[i] <= bpuPkg::ctrStrongNotTaken;
            end
        end else if (exValid) begin
            ctrArr[wrIndex] <= ctrNext;
        end
    end

    // upper bit means taken
    // same-cycle update is not bypassed, lookup sees the old counter
    assign taken = ctrArr[rdIndex][1];

endmodule

// ==== rtl/returnAddressStack.sv ====
// 16-entry circular return stack, no overflow or underflow detection
// overflow overwrites the oldest entry; no repair after a mispredict
`timescale 1ns/100ps

module returnAddressStack (
    input  logic                       clk,
    input  logic                       resetn,
    // call resolved, store its return address
    input  logic                       push,
    // return resolved, drop the newest entry
    input  logic                       pop,
    input  logic [bpuPkg::pcWidth-1:0] pushAddr,
    // newest return address
    output logic [bpuPkg::pcWidth-1:0] top
);

    // entries and next free slot
    logic [bpuPkg::pcWidth-1:0]    stackArr [bpuPkg::rasDepth];
    logic [bpuPkg::rasPtrWidth-1:0] ptr;

    // slot holding the newest entry, wraps below zero
    logic [bpuPkg::rasPtrWidth-1:0] ptrBelow;

    assign ptrBelow = ptr - 1'b1;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ptr <= '0;
            for (int i = 0; i < bpuPkg::rasDepth; i++) begin
                stackArr[i] <= '0;
            end
        end else if (push) begin
            // push wins if both show up together
            stackArr[ptr] <= pushAddr;
            ptr <= ptr + 1'b1;
        end else if (pop) begin
            // entry stays in place, only the pointer moves
            ptr <= ptrBelow;
        end
    end

    // top of stack, old value during a same-cycle push or pop
    assign top = stackArr[ptrBelow];

endmodule

// ==== rtl/branchTargetBuffer.sv ====
// direct-mapped 32-entry target buffer with full 25-bit tags
// returns take their target from the stack, not from the stored target
// only taken control-flow reports allocate; not-taken ones never evict
`timescale 1ns/100ps

module branchTargetBuffer (
    input  logic                       clk,
    input  logic                       resetn,
    // fetch lookup
    input  logic [bpuPkg::pcWidth-1:0] pc,
    // execute report
    input  logic                       exValid,
    input  logic [bpuPkg::pcWidth-1:0] exPc,
    input  logic                       exTaken,
    input  logic [1:0]                 exKind,
    input  logic [bpuPkg::pcWidth-1:0] exTarget,
    // lookup result
    output logic                       hit,
    output logic                       isReturn,
    output logic [bpuPkg::pcWidth-1:0] target
);

    // entry arrays, only valid has a reset
    logic                           validArr  [bpuPkg::btbDepth];
    logic [bpuPkg::btbTagWidth-1:0] tagArr    [bpuPkg::btbDepth];
    logic [1:0]                     kindArr   [bpuPkg::btbDepth];
    logic [bpuPkg::pcWidth-1:0]     targetArr [bpuPkg::btbDepth];

    // fetch side, index pc[6:2] and tag pc[31:7]
    logic [bpuPkg::btbIndexWidth-1:0] rdIndex;
    logic [bpuPkg::btbTagWidth-1:0]   rdTag;

    // execute side slices
    logic [bpuPkg::btbIndexWidth-1:0] wrIndex;
    logic [bpuPkg::btbTagWidth-1:0]   wrTag;

    // decoded report
    logic                       resolvedTaken;
    logic                       wrEn;
    logic [bpuPkg::pcWidth-1:0] wrTarget;

    // stack control
    logic                       rasPush;
    logic                       rasPop;
    logic [bpuPkg::pcWidth-1:0] rasPushAddr;
    logic [bpuPkg::pcWidth-1:0] rasTop;

    assign rdIndex = pc[bpuPkg::btbIndexWidth+1:2];
    assign rdTag = pc[bpuPkg::pcWidth-1:bpuPkg::btbIndexWidth+2];
    assign wrIndex = exPc[bpuPkg::btbIndexWidth+1:2];
    assign wrTag = exPc[bpuPkg::pcWidth-1:bpuPkg::btbIndexWidth+2];

    // lookup, old contents during a same-cycle write
    assign hit = validArr[rdIndex] && (tagArr[rdIndex] == rdTag);
    assign isReturn = hit && (kindArr[rdIndex] == bpuPkg::kindReturn);

    // returns read the stack, everything else the stored target
    assign target = isReturn ? rasTop : targetArr[rdIndex];

    // taken control-flow report from execute
    assign resolvedTaken = exValid && exTaken;
    assign wrEn = resolvedTaken && (exKind != bpuPkg::kindNone);

    // return entries keep no target of their own
    assign wrTarget = (exKind == bpuPkg::kindReturn) ? '0 : exTarget;

    // call pushes its return address, return pops
    assign rasPush = resolvedTaken && (exKind == bpuPkg::kindCall);
    assign rasPop = resolvedTaken && (exKind == bpuPkg::kindReturn);

    // past the call and its delay slot
    assign rasPushAddr = exPc + bpuPkg::returnOffset;

    // valid bits
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < bpuPkg::btbDepth; i++) begin
                validArr[i] <= 1'b0;
            end
        end else if (wrEn) begin
            validArr[wrIndex] <= 1'b1;
        end
    end

    // tag, kind and target payload
    // an alias at the same index simply replaces the entry
    always_ff @(posedge clk) begin
        if (wrEn) begin
            tagArr[wrIndex] <= wrTag;
            kindArr[wrIndex] <= exKind;
            targetArr[wrIndex] <= wrTarget;
        end
    end

    returnAddressStack i_returnAddressStack (
        .clk      (clk),
        .resetn   (resetn),
        .push     (rasPush),
        .pop      (rasPop),
        .pushAddr (rasPushAddr),
        .top      (rasTop)
    );

endmodule

// ==== rtl/branchPredictionUnit.sv ====
// next-PC predictor for fetch, fully combinational from pc to nextPc
// execute reports have no back-pressure; each exValid cycle trains once
`timescale 1ns/100ps

module branchPredictionUnit (
    input  logic                       clk,
    input  logic                       resetn,
    // fetch PC for this cycle
    input  logic [bpuPkg::pcWidth-1:0] pc,
    // resolved instruction from execute
    input  logic                       exValid,
    input  logic [bpuPkg::pcWidth-1:0] exPc,
    input  logic                       exTaken,
    input  logic [1:0]                 exKind,
    input  logic                       exUncond,
    input  logic [bpuPkg::pcWidth-1:0] exTarget,
    // prediction
    output logic [bpuPkg::pcWidth-1:0] nextPc,
    output logic                       predictTaken,
    output logic                       btbHit
);

    // direction from the counter table
    logic                       bhtTaken;

    // target side
    logic                       btbIsReturn;
    logic [bpuPkg::pcWidth-1:0] btbTarget;

    // sequential path
    logic [bpuPkg::pcWidth-1:0] fallThrough;

    branchHistoryTable i_branchHistoryTable (
        .clk      (clk),
        .resetn   (resetn),
        .pc       (pc),
        .exValid  (exValid),
        .exPc     (exPc),
        .exTaken  (exTaken),
        .exUncond (exUncond),
        .taken    (bhtTaken)
    );

    branchTargetBuffer i_branchTargetBuffer (
        .clk      (clk),
        .resetn   (resetn),
        .pc       (pc),
        .exValid  (exValid),
        .exPc     (exPc),
        .exTaken  (exTaken),
        .exKind   (exKind),
        .exTarget (exTarget),
        .hit      (btbHit),
        .isReturn (btbIsReturn),
        .target   (btbTarget)
    );

    assign fallThrough = pc + bpuPkg::fetchStride;

    // a miss is never taken
    // returns are taken regardless of their counter
    assign predictTaken = btbHit && (btbIsReturn || bhtTaken);

    assign nextPc = predictTaken ? btbTarget : fallThrough;

endmodule

// ==== dv/tbBranchPredictionUnit.sv ====
// self-checking testbench with a reference model compared at every falling edge
// stops at the first mismatch; Verilator needs --timing and --assert
`timescale 1ns/100ps

module tbBranchPredictionUnit;

    // about three times the ~2200 cycles of directed and random tests
    localparam int maxCycles = 6000;
    localparam int randomCycles = 2000;

    logic        clk;
    logic        resetn;
    logic [31:0] pc;
    logic        exValid;
    logic [31:0] exPc;
    logic        exTaken;
    logic [1:0]  exKind;
    logic        exUncond;
    logic [31:0] exTarget;
    logic [31:0] nextPc;
    logic        predictTaken;
    logic        btbHit;

    int          cycleCount;
    logic [31:0] lcgState;

    // reference model state
    logic [1:0]  modelCtr    [256];
    logic        modelValid  [32];
    logic [24:0] modelTag    [32];
    logic [1:0]  modelKind   [32];
    logic [31:0] modelTarget [32];
    logic [31:0] modelStack  [16];
    logic [3:0]  modelPtr;

    branchPredictionUnit i_branchPredictionUnit (
        .clk          (clk),
        .resetn       (resetn),
        .pc           (pc),
        .exValid      (exValid),
        .exPc         (exPc),
        .exTaken      (exTaken),
        .exKind       (exKind),
        .exUncond     (exUncond),
        .exTarget     (exTarget),
        .nextPc       (nextPc),
        .predictTaken (predictTaken),
        .btbHit       (btbHit)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // 32-bit LCG
    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // small PC pool with index and tag aliases
    function automatic logic [31:0] poolPc(input logic [2:0] sel);
        case (sel)
            3'd0: return 32'h0000_1000;
            3'd1: return 32'h0000_1004;
            // same buffer index as 0x1000
            3'd2: return 32'h0000_1080;
            // same counter and buffer index as 0x1000
            3'd3: return 32'h0000_1400;
            3'd4: return 32'h0000_2010;
            3'd5: return 32'h0000_2014;
            3'd6: return 32'h0000_2090;
            default: return 32'h0000_3ffc;
        endcase
    endfunction

    task automatic flagMismatch(input string sigName, input logic [31:0] expVal,
                                input logic [31:0] gotVal);
        $display("[FAIL] t=%0t %s expected 0x%08h got 0x%08h", $time, sigName, expVal, gotVal);
        $display("Verification failed");
        $fatal(1, "prediction mismatch");
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "run aborted");
    endtask

    // one execute report, fetch looks at the same PC
    task automatic report(input logic [31:0] rPc, input logic taken, input logic [1:0] kind,
                          input logic uncond, input logic [31:0] tgt);
        @(posedge clk);
        pc <= rPc;
        exValid <= 1'b1;
        exPc <= rPc;
        exTaken <= taken;
        exKind <= kind;
        exUncond <= uncond;
        exTarget <= tgt;
    endtask

    // fetch only, checked against a directed expectation
    task automatic lookup(input logic [31:0] fetchPc, input logic expHit,
                          input logic expTaken, input logic [31:0] expNext);
        @(posedge clk);
        pc <= fetchPc;
        exValid <= 1'b0;
        exTaken <= 1'b0;
        exKind <= bpuPkg::kindNone;
        exUncond <= 1'b0;
        @(negedge clk);
        assert (btbHit === expHit)
            else flagMismatch("btbHit", 32'(expHit), 32'(btbHit));
        assert (predictTaken === expTaken)
            else flagMismatch("predictTaken", 32'(expTaken), 32'(predictTaken));
        assert (nextPc === expNext)
            else flagMismatch("nextPc", expNext, nextPc);
    endtask

    // random fetch and report over the pool
    task automatic driveRandomCycle();
        logic [31:0] r;
        logic [31:0] tgt;
        r = nextRand();
        tgt = nextRand() & 32'hffff_fffc;
        @(posedge clk);
        pc <= poolPc(r[18:16]);
        exValid <= r[24];
        exPc <= poolPc(r[21:19]);
        exTaken <= r[25];
        exKind <= r[27:26];
        // always-taken jumps are rare and only ever taken
        exUncond <= r[25] & (r[30:28] == 3'd0);
        exTarget <= tgt;
    endtask

    // model follows the update rules on the same edge as the DUT
    always @(posedge clk) begin : updateModel
        logic [7:0] ctrIdx;
        logic [4:0] entryIdx;
        logic [1:0] ctrVal;
        ctrIdx = exPc[9:2];
        entryIdx = exPc[6:2];
        ctrVal = modelCtr[ctrIdx];
        if (!resetn) begin
            for (int i = 0; i < 256; i++) begin
                modelCtr[i] <= bpuPkg::ctrStrongNotTaken;
            end
            for (int i = 0; i < 32; i++) begin
                modelValid[i] <= 1'b0;
            end
            for (int i = 0; i < 16; i++) begin
                modelStack[i] <= '0;
            end
            modelPtr <= '0;
        end else if (exValid) begin
            // saturating counter
            if (exUncond) begin
                modelCtr[ctrIdx] <= bpuPkg::ctrStrongTaken;
            end else if (exTaken && ctrVal != bpuPkg::ctrStrongTaken) begin
                modelCtr[ctrIdx] <= ctrVal + 2'd1;
            end else if (!exTaken && ctrVal != bpuPkg::ctrStrongNotTaken) begin
                modelCtr[ctrIdx] <= ctrVal - 2'd1;
            end
            // buffer fill on taken control flow
            if (exTaken && exKind != bpuPkg::kindNone) begin
                modelValid[entryIdx] <= 1'b1;
                modelTag[entryIdx] <= exPc[31:7];
                modelKind[entryIdx] <= exKind;
                modelTarget[entryIdx] <= (exKind == bpuPkg::kindReturn) ? 32'd0 : exTarget;
            end
            // stack push and pop
            if (exTaken && exKind == bpuPkg::kindCall) begin
                modelStack[modelPtr] <= exPc + 32'd8;
                modelPtr <= modelPtr + 4'd1;
            end else if (exTaken && exKind == bpuPkg::kindReturn) begin
                modelPtr <= modelPtr - 4'd1;
            end
        end
    end

    // inputs and outputs are settled half a cycle after the drive edge
    always @(negedge clk) begin : checkPrediction
        logic [4:0]  entryIdx;
        logic [3:0]  topIdx;
        logic        expHit;
        logic        expReturn;
        logic        expTaken;
        logic [31:0] expTarget;
        logic [31:0] expNext;
        entryIdx = pc[6:2];
        topIdx = modelPtr - 4'd1;
        expHit = modelValid[entryIdx] && (modelTag[entryIdx] == pc[31:7]);
        expReturn = expHit && (modelKind[entryIdx] == bpuPkg::kindReturn);
        expTaken = expHit && (expReturn || modelCtr[pc[9:2]][1]);
        expTarget = expReturn ? modelStack[topIdx] : modelTarget[entryIdx];
        expNext = expTaken ? expTarget : pc + 32'd4;
        if (resetn) begin
            assert (btbHit === expHit)
                else flagMismatch("btbHit", 32'(expHit), 32'(btbHit));
            assert (predictTaken === expTaken)
                else flagMismatch("predictTaken", 32'(expTaken), 32'(predictTaken));
            assert (nextPc === expNext)
                else flagMismatch("nextPc", expNext, nextPc);
        end
    end

    // run length guard
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            abortRun("Timeout: the tests did not finish within the cycle limit");
        end
    end

    initial begin : stimulus
        logic [31:0] randPc;
        logic [31:0] callPc;
        resetn = 1'b0;
        pc = '0;
        exValid = 1'b0;
        exPc = '0;
        exTaken = 1'b0;
        exKind = bpuPkg::kindNone;
        exUncond = 1'b0;
        exTarget = '0;
        cycleCount = 0;
        lcgState = 32'd56;
        repeat (16) @(posedge clk);
        resetn <= 1'b1;

        // empty tables fall through
        for (int i = 0; i < 50; i++) begin
            randPc = nextRand() & 32'hffff_fffc;
            lookup(randPc, 1'b0, 1'b0, randPc + 32'd4);
        end

        // conditional branch needs two taken reports
        report(32'h0000_0410, 1'b1, bpuPkg::kindJump, 1'b0, 32'h0000_0800);
        lookup(32'h0000_0410, 1'b1, 1'b0, 32'h0000_0414);
        report(32'h0000_0410, 1'b1, bpuPkg::kindJump, 1'b0, 32'h0000_0800);
        lookup(32'h0000_0410, 1'b1, 1'b1, 32'h0000_0800);
        repeat (3) report(32'h0000_0410, 1'b0, bpuPkg::kindJump, 1'b0, 32'h0000_0800);
        lookup(32'h0000_0410, 1'b1, 1'b0, 32'h0000_0414);
        // saturated at strong not taken so one taken report stays not taken
        report(32'h0000_0410, 1'b1, bpuPkg::kindJump, 1'b0, 32'h0000_0800);
        lookup(32'h0000_0410, 1'b1, 1'b0, 32'h0000_0414);

        // unconditional jump predicted right away
        report(32'h0000_0a20, 1'b1, bpuPkg::kindJump, 1'b1, 32'h0000_4000);
        lookup(32'h0000_0a20, 1'b1, 1'b1, 32'h0000_4000);

        // index alias with a different tag
        report(32'h0000_0530, 1'b1, bpuPkg::kindJump, 1'b1, 32'h0000_5000);
        lookup(32'h0000_0530, 1'b1, 1'b1, 32'h0000_5000);
        lookup(32'h0001_0530, 1'b0, 1'b0, 32'h0001_0534);
        report(32'h0001_0530, 1'b1, bpuPkg::kindJump, 1'b1, 32'h0000_5800);
        lookup(32'h0001_0530, 1'b1, 1'b1, 32'h0000_5800);
        lookup(32'h0000_0530, 1'b0, 1'b0, 32'h0000_0534);

        // train the return first, its pop wraps the empty stack
        report(32'h0000_307c, 1'b1, bpuPkg::kindReturn, 1'b0, 32'h0000_0000);
        for (int k = 0; k < 3; k++) begin
            callPc = 32'h0000_2000 + 32'(k) * 32'h0000_0104;
            report(callPc, 1'b1, bpuPkg::kindCall, 1'b1, 32'h0000_7000);
        end
        // returns unwind in reverse order
        for (int k = 2; k >= 0; k--) begin
            callPc = 32'h0000_2000 + 32'(k) * 32'h0000_0104;
            lookup(32'h0000_307c, 1'b1, 1'b1, callPc + 32'd8);
            report(32'h0000_307c, 1'b1, bpuPkg::kindReturn, 1'b0, 32'h0000_0000);
        end

        // seventeen calls overflow the stack
        for (int i = 0; i < 17; i++) begin
            callPc = 32'h0000_6000 + 32'(i) * 32'd4;
            report(callPc, 1'b1, bpuPkg::kindCall, 1'b1, 32'h0000_7400);
        end
        // newest sixteen come back, the first call is gone
        for (int k = 16; k >= 1; k--) begin
            callPc = 32'h0000_6000 + 32'(k) * 32'd4;
            lookup(32'h0000_307c, 1'b1, 1'b1, callPc + 32'd8);
            report(32'h0000_307c, 1'b1, bpuPkg::kindReturn, 1'b0, 32'h0000_0000);
        end

        // random mix, the model check covers every cycle
        for (int i = 0; i < randomCycles; i++) begin
            driveRandomCycle();
        end
        // last random cycle gets its falling-edge check first
        repeat (2) @(negedge clk);

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== files.f ====
rtl/bpuPkg.sv
rtl/branchHistoryTable.sv
rtl/returnAddressStack.sv
rtl/branchTargetBuffer.sv
rtl/branchPredictionUnit.sv
dv/tbBranchPredictionUnit.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the branch prediction unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tbBranchPredictionUnit -Mdir obj_dir -f files.f

# the simulator exits non-zero on failure, the search below decides
out=$(./obj_dir/VtbBranchPredictionUnit 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Verification passed"; then
    exit 0
else
    exit 1
fi
